// File: build.f
common/flp_pkg.sv
common/flp_unp_if.sv
flp_mul/flp_unpack.sv
flp_mul/flp_mul_core.sv
flp_mul/flp_round.sv
flp_mul/flp_pack.sv
rtl/flp_csr.sv
rtl/flp_mul_top.sv
bench/flp_mul_checker.sv
bench/flp_mul_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project directory"
  exit 1
fi

verilator --binary --timing -Wno-fatal --top-module flp_mul_tb -f build.f -o flp_mul_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/flp_mul_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1

// File: bench/flp_mul_tb.sv
/* Testbench top for the multiplier, applies a table of operands and checks results through the scoreboard */
`timescale 1ns/1ns
`default_nettype none

module flp_mul_tb
  import flp_pkg::*;
();

  localparam int CLK_PERIOD = 4;            /* ns */
  localparam int NUM_ROWS   = 22;           /* Rows in the stimulus table */
  localparam int MAX_GAP    = 3;            /* Longest idle gap between rows */
  localparam int SEED       = 59541;
  localparam int WATCHDOG_NS = NUM_ROWS * (MAX_GAP + FLP_LATENCY + 20) * CLK_PERIOD;

  logic             clk;
  logic             rst;
  logic             op_valid;
  logic [31:0]      op_a;
  logic [31:0]      op_b;
  logic             rm_we;
  flp_rmode_e       rm_in;
  logic             flag_clr;
  logic             res_valid;
  logic [31:0]      res_word;
  logic [FLG_W-1:0] flags;
  flp_rmode_e       rm_out;

  string            row_name[NUM_ROWS];     /* Stimulus table, one entry per row */
  flp_rmode_e       row_rm[NUM_ROWS];
  logic [31:0]      row_a[NUM_ROWS];
  logic [31:0]      row_b[NUM_ROWS];
  logic [31:0]      row_res[NUM_ROWS];      /* Expected product word */
  logic [FLG_W-1:0] row_flg[NUM_ROWS];      /* Expected sticky flags after the row */
  logic             row_chk[NUM_ROWS];      /* Drain, compare flags and clear after the row */
  logic             row_burst[NUM_ROWS];    /* Next row follows with no gap */
  int               n_rows = 0;
  int               gap;
  flp_rmode_e       cur_rm;

  flp_mul_top #(.EWIDTH(8), .SWIDTH(23)) dut (
    .i_clk(clk), .i_rst(rst), .i_valid(op_valid), .i_a(op_a), .i_b(op_b),
    .i_rm_we(rm_we), .i_rm(rm_in), .i_flag_clr(flag_clr),
    .o_valid(res_valid), .o_result(res_word), .o_flags(flags), .o_rm(rm_out)
  );

  flp_mul_checker #(.WIDTH(32)) u_chk (
    .i_clk(clk), .i_rst(rst), .i_valid(res_valid), .i_result(res_word),
    .i_flags(flags), .i_rm(rm_out)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  task add_row(input string name, input flp_rmode_e rm, input logic [31:0] a,
               input logic [31:0] b, input logic [31:0] res, input logic [3:0] flg,
               input logic chk, input logic burst);
    row_name[n_rows]  = name;
    row_rm[n_rows]    = rm;
    row_a[n_rows]     = a;
    row_b[n_rows]     = b;
    row_res[n_rows]   = res;
    row_flg[n_rows]   = flg;
    row_chk[n_rows]   = chk;
    row_burst[n_rows] = burst;
    n_rows++;
  endtask

  /* Expected words worked out by hand from IEEE 754 single precision rules */
  task load_table();
    add_row("exact_1p5x2",      RM_RNE, 32'h3FC00000, 32'h40000000, 32'h40400000, 4'h0, 0, 1);
    add_row("exact_m3x0p5",     RM_RNE, 32'hC0400000, 32'h3F000000, 32'hBFC00000, 4'h0, 0, 1);
    add_row("exact_2x2",        RM_RNE, 32'h40000000, 32'h40000000, 32'h40800000, 4'h0, 0, 1);
    add_row("exact_1x1",        RM_RNE, 32'h3F800000, 32'h3F800000, 32'h3F800000, 4'h0, 1, 0);
    add_row("exact_1p5x2_rtz",  RM_RTZ, 32'h3FC00000, 32'h40000000, 32'h40400000, 4'h0, 0, 0);
    add_row("exact_m3x0p5_rtz", RM_RTZ, 32'hC0400000, 32'h3F000000, 32'hBFC00000, 4'h0, 1, 0);
    add_row("tie_odd_rtz",      RM_RTZ, 32'h3F800001, 32'h3FC00000, 32'h3FC00001, 4'h8, 1, 0);
    add_row("carry_rtz",        RM_RTZ, 32'h3FC80000, 32'h3FA3D70A, 32'h3FFFFFFF, 4'h8, 1, 0);
    add_row("ovf_rtz",          RM_RTZ, 32'h7F000000, 32'h40000000, 32'h7F7FFFFF, 4'hA, 1, 0);
    add_row("tie_odd_rne",      RM_RNE, 32'h3F800001, 32'h3FC00000, 32'h3FC00002, 4'h8, 1, 0);
    add_row("tie_even_rne",     RM_RNE, 32'h3F800003, 32'h3FC00000, 32'h3FC00004, 4'h8, 1, 0);
    add_row("carry_rne",        RM_RNE, 32'h3FC80000, 32'h3FA3D70A, 32'h40000000, 4'h8, 1, 0);
    add_row("nan_in",           RM_RNE, 32'h7FC00000, 32'hC0000000, 32'hFFFFFFFF, 4'h0, 1, 0);
    add_row("inf_x_zero",       RM_RNE, 32'h7F800000, 32'h00000000, 32'h7FFFFFFF, 4'h1, 1, 0);
    add_row("minf_x_2",         RM_RNE, 32'hFF800000, 32'h40000000, 32'hFF800000, 4'h0, 0, 0);
    add_row("mzero_x_3",        RM_RNE, 32'h80000000, 32'h40400000, 32'h80000000, 4'h0, 0, 0);
    add_row("subnorm_x_1",      RM_RNE, 32'h00400000, 32'h3F800000, 32'h00000000, 4'h0, 1, 0);
    add_row("ovf_rne",          RM_RNE, 32'hFF000000, 32'h40000000, 32'hFF800000, 4'hA, 0, 0);
    add_row("clean_after_ovf",  RM_RNE, 32'h40000000, 32'h3F000000, 32'h3F800000, 4'hA, 0, 0);
    add_row("clean_after_ovf2", RM_RNE, 32'h3FC00000, 32'h3FC00000, 32'h40100000, 4'hA, 1, 0);
    add_row("unf_rne",          RM_RNE, 32'h80800000, 32'h3F000000, 32'h80000000, 4'hC, 1, 0);
    add_row("unf_rtz",          RM_RTZ, 32'h00800000, 32'h3F000000, 32'h00000000, 4'hC, 1, 0);
  endtask

  /* Waits at falling edges until every issued result is back, bounded by the latency */
  task wait_drain();
    int n;
    n = 0;
    while (u_chk.pending() != 0 && n < FLP_LATENCY + 4)
    begin
      @(negedge clk);
      n++;
    end
    @(negedge clk);                         /* Sticky flags land one edge after the last pulse */
  endtask

  task write_mode(input string name, input flp_rmode_e mode);
    rm_in = mode;
    rm_we = 1'b1;
    @(negedge clk);
    rm_we = 1'b0;
    u_chk.check_rm(name, mode);             /* Register took the value on the edge between */
    cur_rm = mode;
  endtask

  task clear_flags(input string name);
    flag_clr = 1'b1;
    @(negedge clk);
    flag_clr = 1'b0;
    u_chk.check_flags({name, "_clr"}, '0);
  endtask

  initial
  begin
    op_valid = 1'b0;
    op_a     = '0;
    op_b     = '0;
    rm_we    = 1'b0;
    rm_in    = RM_RNE;
    flag_clr = 1'b0;
    rst      = 1'b1;
    void'($urandom(SEED));                  /* Gaps repeat from run to run */
    load_table();
    repeat (10) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    u_chk.check_rm("reset", RM_RNE);
    u_chk.check_flags("reset", '0);
    cur_rm = RM_RNE;
    for (int i = 0; i < n_rows; i++)
    begin
      if (row_rm[i] != cur_rm)
      begin
        wait_drain();                       /* Mode only changes with the pipeline empty */
        write_mode(row_name[i], row_rm[i]);
      end
      op_valid = 1'b1;
      op_a     = row_a[i];
      op_b     = row_b[i];
      u_chk.push_expected(row_name[i], row_res[i]);
      @(negedge clk);
      op_valid = 1'b0;
      if (!row_burst[i])
      begin
        gap = ($urandom % 2 == 0) ? 0 : 1 + int'($urandom % MAX_GAP);
        repeat (gap) @(negedge clk);
      end
      if (row_chk[i])
      begin
        wait_drain();
        u_chk.check_flags(row_name[i], row_flg[i]);
        clear_flags(row_name[i]);
      end
    end
    wait_drain();
    u_chk.final_check();
    u_chk.check_depth(FLP_LATENCY);         /* The opening burst keeps four in flight */
    $display("Errors: %0d value, %0d flag, %0d protocol",
             u_chk.value_errs, u_chk.flag_errs, u_chk.proto_errs);
    if (u_chk.value_errs + u_chk.flag_errs + u_chk.proto_errs == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  /* Budget covers every row with its longest gap, drain and flag clear */
  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/flp_mul_checker.sv
/* Testbench scoreboard that queues expected products and compares results, flags and mode with the DUT */
`timescale 1ns/1ns
`default_nettype none

module flp_mul_checker
  import flp_pkg::*;
#(
  parameter int WIDTH = 32                  /* Result word width */
)
(
  input  wire              i_clk,           /* Clock */
  input  wire              i_rst,           /* Reset, results are ignored while high */
  input  wire              i_valid,         /* DUT result strobe */
  input  wire [WIDTH-1:0]  i_result,        /* DUT result word */
  input  wire [FLG_W-1:0]  i_flags,         /* DUT sticky flags */
  input  var flp_rmode_e   i_rm             /* DUT rounding mode */
);

  logic [WIDTH-1:0] exp_q[$];               /* Expected results in issue order */
  string            name_q[$];              /* Test names matching exp_q */
  int               issue_q[$];             /* Edge count when each operation was queued */
  logic [WIDTH-1:0] exp_v;                  /* Entry popped for the current compare */
  string            name_v;
  int               issue_v;
  int               cyc        = 0;         /* Rising edges seen so far */
  int               value_errs = 0;         /* Wrong result words */
  int               flag_errs  = 0;         /* Wrong flag or mode readings */
  int               proto_errs = 0;         /* Missing, extra, late or stalled results */
  int               max_depth  = 0;         /* Most operations seen in flight */

  task push_expected(input string name, input logic [WIDTH-1:0] value);
    exp_q.push_back(value);
    name_q.push_back(name);
    issue_q.push_back(cyc);                 /* Operand is taken on the next rising edge */
    if (exp_q.size() > max_depth)
      max_depth = exp_q.size();             /* Tracks overlap of back-to-back issue */
  endtask

  function int pending();
    return exp_q.size();
  endfunction

  task check_flags(input string name, input logic [FLG_W-1:0] expected);
    if (i_flags !== expected)
    begin
      flag_errs++;
      $display("Error %s flags: expected %h, actual %h", name, expected, i_flags);
    end
  endtask

  task check_rm(input string name, input flp_rmode_e expected);
    if (i_rm !== expected)
    begin
      flag_errs++;
      $display("Error %s mode: expected %0d, actual %0d", name, expected, i_rm);
    end
  endtask

  task check_depth(input int needed);
    if (max_depth < needed)
    begin
      proto_errs++;
      $display("Pipeline never held %0d operations at once, deepest was %0d", needed, max_depth);
    end
  endtask

  task final_check();
    while (exp_q.size() != 0)
    begin
      proto_errs++;
      exp_v   = exp_q.pop_front();
      name_v  = name_q.pop_front();
      issue_v = issue_q.pop_front();
      $display("Result for %s never arrived, %h was still expected", name_v, exp_v);
    end
  endtask

  /* Values are sampled at the rising edge, before the DUT registers move */
  always @(posedge i_clk)
  begin
    if (!i_rst && i_valid)
    begin
      if (exp_q.size() == 0)
      begin
        proto_errs++;
        $display("Result %h arrived at %0t ns with no operation outstanding", i_result, $time);
      end
      else
      begin
        exp_v   = exp_q.pop_front();
        name_v  = name_q.pop_front();
        issue_v = issue_q.pop_front();
        if (i_result !== exp_v)
        begin
          value_errs++;
          $display("Error %s: expected %h, actual %h", name_v, exp_v, i_result);
        end
        if (cyc - issue_v != FLP_LATENCY)
        begin
          proto_errs++;
          $display("Result for %s came %0d cycles after its operands instead of %0d",
                   name_v, cyc - issue_v, FLP_LATENCY);
        end
      end
    end
    cyc++;                                  /* Edges between issue and compare give the latency */
  end

endmodule

`default_nettype wire

// File: rtl/flp_mul_top.sv
/* Top level of the pipelined single precision multiplier, result four cycles after each i_valid */
`timescale 1ns/1ns
`default_nettype none

module flp_mul_top
  import flp_pkg::*;
#(
  parameter int EWIDTH = 8,   /* Exponent width */
  parameter int SWIDTH = 23   /* Fraction width */
)
(
  input  wire                     i_clk,       /* Clock */
  input  wire                     i_rst,       /* Synchronous reset, active high */
  input  wire                     i_valid,     /* Operand strobe, one op per cycle at most */
  input  wire [EWIDTH+SWIDTH:0]   i_a,         /* Operand A */
  input  wire [EWIDTH+SWIDTH:0]   i_b,         /* Operand B */
  input  wire                     i_rm_we,     /* Rounding mode write */
  input  var flp_rmode_e          i_rm,        /* Rounding mode value */
  input  wire                     i_flag_clr,  /* Sticky flag clear */
  output logic                    o_valid,     /* Result strobe, FLP_LATENCY after i_valid */
  output logic [EWIDTH+SWIDTH:0]  o_result,    /* Product word */
  output logic [FLG_W-1:0]        o_flags,     /* Sticky exception flags */
  output flp_rmode_e              o_rm         /* Current rounding mode */
);

  flp_unp_if #(.EWIDTH(EWIDTH), .SWIDTH(SWIDTH)) unp_a ();  /* Unpacked A */
  flp_unp_if #(.EWIDTH(EWIDTH), .SWIDTH(SWIDTH)) unp_b ();  /* Unpacked B */
  flp_unp_if #(.EWIDTH(EWIDTH), .SWIDTH(SWIDTH)) res ();    /* Rounded result */

  logic                     core_sn;
  logic                     core_zero;
  logic                     core_nan;
  logic                     core_inf;
  logic                     core_valid;
  logic                     core_invalid;
  logic signed [EWIDTH+1:0] core_ex_sum;
  logic [2*SWIDTH+1:0]      core_prod;
  logic [FLG_W-1:0]         exc;        /* Rounder pulse into the CSR */

  flp_unpack #(.EWIDTH(EWIDTH), .SWIDTH(SWIDTH)) u_unp_a (
    .i_clk(i_clk), .i_rst(i_rst), .i_valid(i_valid), .i_fpd(i_a), .o_unp(unp_a)
  );

  flp_unpack #(.EWIDTH(EWIDTH), .SWIDTH(SWIDTH)) u_unp_b (
    .i_clk(i_clk), .i_rst(i_rst), .i_valid(i_valid), .i_fpd(i_b), .o_unp(unp_b)
  );

  flp_mul_core #(.EWIDTH(EWIDTH), .SWIDTH(SWIDTH)) u_core (
    .i_clk(i_clk), .i_rst(i_rst), .i_a(unp_a), .i_b(unp_b),
    .o_sn(core_sn), .o_zero(core_zero), .o_nan(core_nan), .o_inf(core_inf),
    .o_valid(core_valid), .o_ex_sum(core_ex_sum), .o_prod(core_prod),
    .o_invalid(core_invalid)
  );

  flp_round #(.EWIDTH(EWIDTH), .SWIDTH(SWIDTH)) u_round (
    .i_clk(i_clk), .i_rst(i_rst), .i_sn(core_sn), .i_zero(core_zero),
    .i_nan(core_nan), .i_inf(core_inf), .i_valid(core_valid),
    .i_ex_sum(core_ex_sum), .i_prod(core_prod), .i_invalid(core_invalid),
    .i_rm(o_rm), .o_res(res), .o_exc(exc)
  );

  flp_pack #(.EWIDTH(EWIDTH), .SWIDTH(SWIDTH)) u_pack (
    .i_unp(res), .o_fpd(o_result)  /* Combinational after the rounder registers */
  );

  flp_csr u_csr (
    .i_clk(i_clk), .i_rst(i_rst), .i_rm_we(i_rm_we), .i_rm(i_rm),
    .i_flag_clr(i_flag_clr), .i_exc(exc), .o_rm(o_rm), .o_flags(o_flags)
  );

  assign o_valid = res.valid;

endmodule

`default_nettype wire

// File: rtl/flp_csr.sv
/* Control and status registers holding the rounding mode and the sticky exception flags */
`timescale 1ns/1ns
`default_nettype none

module flp_csr
  import flp_pkg::*;
(
  input  wire                 i_clk,       /* Clock */
  input  wire                 i_rst,       /* Synchronous reset, active high */
  input  wire                 i_rm_we,     /* Write strobe for the mode register */
  input  var flp_rmode_e      i_rm,        /* New rounding mode */
  input  wire                 i_flag_clr,  /* Clears the sticky flags */
  input  wire [FLG_W-1:0]     i_exc,       /* Exception pulse from the rounder */
  output flp_rmode_e          o_rm,        /* Mode steering the rounder */
  output logic [FLG_W-1:0]    o_flags      /* Accumulated exceptions */
);

  /* Mode register, written on the edge after the strobe */
  always_ff @(posedge i_clk)
  begin
    if (i_rst)
      o_rm <= RM_RNE;  /* Default IEEE mode */
    else if (i_rm_we)
      o_rm <= i_rm;
  end

  /*
   * Sticky flags. A clear drops the old bits, but a pulse in the same
   * cycle is still ORed in, so a fresh exception is never lost
   */
  always_ff @(posedge i_clk)
  begin
    if (i_rst)
      o_flags <= '0;
    else
      o_flags <= (i_flag_clr ? '0 : o_flags) | i_exc;
  end

endmodule

`default_nettype wire

// File: flp_mul/flp_pack.sv
/* Combinational pack stage that encodes final fields into an IEEE result word with special values */
`timescale 1ns/1ns
`default_nettype none

module flp_pack #(
  parameter int EWIDTH = 8,   /* Exponent width */
  parameter int SWIDTH = 23   /* Fraction width */
)
(
  flp_unp_if.dst                  i_unp,  /* Final fields from the rounder */
  output logic [EWIDTH+SWIDTH:0]  o_fpd   /* IEEE 754 result word */
);

  logic [EWIDTH-1:0] ex;    /* Encoded exponent */
  logic [SWIDTH-1:0] frac;  /* Encoded fraction, hidden one dropped */

  /* Specials force the exponent to one of its two reserved values */
  always_comb
  begin
    ex = i_unp.ex;
    if (i_unp.nan || i_unp.inf)
      ex = '1;
    else if (i_unp.zero)
      ex = '0;
  end

  /* NaN is canonical with every fraction bit set */
  always_comb
  begin
    frac = i_unp.sg[SWIDTH-1:0];
    if (i_unp.nan)
      frac = '1;
    else if (i_unp.inf || i_unp.zero)
      frac = '0;
  end

  assign o_fpd = {i_unp.sn, ex, frac};  /* Sign always passes through */

endmodule

`default_nettype wire

// File: flp_mul/flp_round.sv
/* Registered normalize and round stage producing final fields and a one-cycle exception pulse word */
`timescale 1ns/1ns
`default_nettype none

module flp_round
  import flp_pkg::*;
#(
  parameter int EWIDTH = 8,   /* Exponent width */
  parameter int SWIDTH = 23   /* Fraction width */
)
(
  input  wire                          i_clk,      /* Clock */
  input  wire                          i_rst,      /* Synchronous reset, active high */
  input  wire                          i_sn,       /* Product sign */
  input  wire                          i_zero,     /* Product is zero */
  input  wire                          i_nan,      /* Product is NaN */
  input  wire                          i_inf,      /* Product is infinity */
  input  wire                          i_valid,    /* Core strobe */
  input  wire signed [EWIDTH+1:0]      i_ex_sum,   /* Biased exponent before normalizing */
  input  wire [2*SWIDTH+1:0]           i_prod,     /* Full significand product */
  input  wire                          i_invalid,  /* Infinity times zero */
  input  var flp_rmode_e               i_rm,       /* Current rounding mode */
  flp_unp_if.src                       o_res,      /* Final fields for pack */
  output logic [FLG_W-1:0]             o_exc       /* Exception pulse, valid with o_res.valid */
);

  localparam int PW = 2*SWIDTH+2;  /* Product width */
  localparam logic signed [EWIDTH+1:0] EXP_MAX = (1 << EWIDTH) - 1;  /* Reserved exponent */

  logic                     top;       /* Product lies in [2,4) */
  logic [PW-1:0]            prod_n;    /* Product with the leading one at the top */
  logic [SWIDTH:0]          mant;      /* Kept significand before rounding */
  logic                     guard;     /* First dropped bit */
  logic                     rnd;       /* Second dropped bit */
  logic                     sticky;    /* OR of the rest */
  logic                     inexact;
  logic                     round_up;
  logic [SWIDTH+1:0]        mant_r;    /* Rounded significand with carry bit */
  logic [SWIDTH:0]          mant_f;    /* Rounded and renormalized */
  logic signed [EWIDTH+1:0] ex_n;      /* Final unclamped exponent */
  logic                     ovf;
  logic                     unf;

  logic                     n_zero;    /* Next register values */
  logic                     n_nan;
  logic                     n_inf;
  logic [EWIDTH-1:0]        n_ex;
  logic [SWIDTH:0]          n_sg;
  logic [FLG_W-1:0]         n_exc;

  assign top    = i_prod[PW-1];
  assign prod_n = top ? i_prod : {i_prod[PW-2:0], 1'b0};  /* Same as a right shift of the kept bits */
  assign mant   = prod_n[PW-1 -: SWIDTH+1];
  assign guard  = prod_n[PW-SWIDTH-2];
  assign rnd    = prod_n[PW-SWIDTH-3];
  assign sticky = |prod_n[PW-SWIDTH-4:0];
  assign inexact = guard | rnd | sticky;

  /* Ties go to the even significand; RTZ never increments */
  assign round_up = (i_rm == RM_RNE) && guard && (rnd || sticky || mant[0]);
  assign mant_r   = {1'b0, mant} + {{(SWIDTH+1){1'b0}}, round_up};
  assign mant_f   = mant_r[SWIDTH+1] ? mant_r[SWIDTH+1:1] : mant_r[SWIDTH:0];  /* Carry out renormalizes */
  assign ex_n     = i_ex_sum + $signed({{(EWIDTH+1){1'b0}}, top})
                    + $signed({{(EWIDTH+1){1'b0}}, mant_r[SWIDTH+1]});
  assign ovf      = (ex_n >= EXP_MAX);
  assign unf      = (ex_n <= 0);  /* No subnormal output */

  always_comb
  begin
    n_zero = 1'b0;
    n_nan  = 1'b0;
    n_inf  = 1'b0;
    n_ex   = ex_n[EWIDTH-1:0];
    n_sg   = mant_f;
    n_exc  = '0;
    if (i_nan)
    begin
      n_nan = 1'b1;
      n_exc[FLG_INVALID] = i_invalid;  /* Only infinity times zero, NaN inputs stay quiet */
    end
    else if (i_inf)
      n_inf = 1'b1;
    else if (i_zero)
      n_zero = 1'b1;
    else if (ovf)
    begin
      n_exc[FLG_OVERFLOW] = 1'b1;
      n_exc[FLG_INEXACT]  = 1'b1;
      if (i_rm == RM_RNE)
        n_inf = 1'b1;
      else
      begin
        n_ex = {{(EWIDTH-1){1'b1}}, 1'b0};  /* Largest finite value */
        n_sg = '1;
      end
    end
    else if (unf)
    begin
      n_zero = 1'b1;  /* Signed zero, the sign is kept */
      n_exc[FLG_UNDERFLOW] = 1'b1;
      n_exc[FLG_INEXACT]   = 1'b1;
    end
    else
      n_exc[FLG_INEXACT] = inexact;
  end

  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      o_res.valid <= 1'b0;
      o_exc       <= '0;
    end
    else
    begin
      o_res.valid <= i_valid;
      o_exc       <= i_valid ? n_exc : '0;  /* Pulse only alongside a result */
    end
  end

  always_ff @(posedge i_clk)
  begin
    o_res.sn   <= i_sn;
    o_res.ex   <= n_ex;
    o_res.sg   <= n_sg;
    o_res.zero <= n_zero;
    o_res.nan  <= n_nan;
    o_res.inf  <= n_inf;
  end

endmodule

`default_nettype wire

// File: flp_mul/flp_mul_core.sv
/* Two-stage multiply core forming sign, biased exponent sum, significand product and special cases */
`timescale 1ns/1ns
`default_nettype none

module flp_mul_core #(
  parameter int EWIDTH = 8,   /* Exponent width */
  parameter int SWIDTH = 23   /* Fraction width */
)
(
  input  wire                          i_clk,      /* Clock */
  input  wire                          i_rst,      /* Synchronous reset, active high */
  flp_unp_if.dst                       i_a,        /* Unpacked operand A */
  flp_unp_if.dst                       i_b,        /* Unpacked operand B */
  output logic                         o_sn,       /* Product sign */
  output logic                         o_zero,     /* Product is zero */
  output logic                         o_nan,      /* Product is NaN */
  output logic                         o_inf,      /* Product is infinity */
  output logic                         o_valid,    /* Strobe for all outputs */
  output logic signed [EWIDTH+1:0]     o_ex_sum,   /* Sum of exponents with one bias removed */
  output logic [2*SWIDTH+1:0]          o_prod,     /* Full significand product */
  output logic                         o_invalid   /* Infinity times zero was seen */
);

  localparam logic signed [EWIDTH+1:0] BIAS = (1 << (EWIDTH-1)) - 1;  /* 127 for single */

  logic                     any_nan;   /* Either operand is NaN */
  logic                     inf_zero;  /* Infinity meets zero */
  logic                     any_inf;   /* Either operand is infinity */
  logic                     any_zero;  /* Either operand is zero */
  logic signed [EWIDTH+1:0] ex_sum;    /* Combinational exponent sum */

  logic                     s1_valid;  /* Stage one strobe */
  logic                     s1_sn;
  logic                     s1_zero;
  logic                     s1_nan;
  logic                     s1_inf;
  logic                     s1_inv;
  logic signed [EWIDTH+1:0] s1_ex;
  logic [SWIDTH:0]          s1_sg_a;   /* Significands held for the multiplier */
  logic [SWIDTH:0]          s1_sg_b;

  assign any_nan  = i_a.nan | i_b.nan;
  assign inf_zero = (i_a.inf & i_b.zero) | (i_b.inf & i_a.zero);  /* Invalid operation */
  assign any_inf  = i_a.inf | i_b.inf;
  assign any_zero = i_a.zero | i_b.zero;

  /* Two biased exponents carry the bias twice, so one copy is taken out */
  assign ex_sum = $signed({2'b00, i_a.ex}) + $signed({2'b00, i_b.ex}) - BIAS;

  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      s1_valid <= 1'b0;
      o_valid  <= 1'b0;
    end
    else
    begin
      s1_valid <= i_a.valid & i_b.valid;  /* Both unpackers fire together */
      o_valid  <= s1_valid;
    end
  end

  /* Stage one resolves signs, exponents and the special cases */
  always_ff @(posedge i_clk)
  begin
    s1_sn   <= i_a.sn ^ i_b.sn;
    s1_ex   <= ex_sum;
    s1_nan  <= any_nan | inf_zero;                   /* NaN in or undefined product */
    s1_inv  <= inf_zero;
    s1_inf  <= any_inf & ~any_nan & ~inf_zero;       /* Infinity times nonzero */
    s1_zero <= any_zero & ~any_nan & ~any_inf;       /* Zero times finite */
    s1_sg_a <= i_a.sg;
    s1_sg_b <= i_b.sg;
  end

  /* Stage two carries the product and realigns the stage one results */
  always_ff @(posedge i_clk)
  begin
    o_prod    <= s1_sg_a * s1_sg_b;  /* Two SWIDTH+1 factors fill 2*SWIDTH+2 bits */
    o_sn      <= s1_sn;
    o_ex_sum  <= s1_ex;
    o_nan     <= s1_nan;
    o_inf     <= s1_inf;
    o_zero    <= s1_zero;
    o_invalid <= s1_inv;
  end

endmodule

`default_nettype wire

// File: flp_mul/flp_unpack.sv
/* Registered unpack stage that splits one IEEE word into fields and zero, NaN and infinity marks */
`timescale 1ns/1ns
`default_nettype none

module flp_unpack #(
  parameter int EWIDTH = 8,   /* Exponent width */
  parameter int SWIDTH = 23   /* Fraction width */
)
(
  input  wire                     i_clk,    /* Clock */
  input  wire                     i_rst,    /* Synchronous reset, active high */
  input  wire                     i_valid,  /* Operand strobe */
  input  wire [EWIDTH+SWIDTH:0]   i_fpd,    /* IEEE 754 operand word */
  flp_unp_if.src                  o_unp     /* Unpacked operand for the core */
);

  logic [EWIDTH-1:0] ex;       /* Raw exponent field */
  logic [SWIDTH-1:0] frac;     /* Raw fraction field */
  logic              ex_zero;  /* Exponent is all zeros */
  logic              ex_ones;  /* Exponent is all ones */
  logic              frac_nz;  /* Fraction has any bit set */

  assign ex      = i_fpd[EWIDTH+SWIDTH-1:SWIDTH];  /* Exponent sits just under the sign */
  assign frac    = i_fpd[SWIDTH-1:0];
  assign ex_zero = (ex == '0);  /* Zero or subnormal, both flushed */
  assign ex_ones = &ex;         /* Infinity or NaN */
  assign frac_nz = |frac;

  /* Only the strobe carries state through reset */
  always_ff @(posedge i_clk)
  begin
    if (i_rst)
      o_unp.valid <= 1'b0;
    else
      o_unp.valid <= i_valid;
  end

  always_ff @(posedge i_clk)
  begin
    o_unp.sn   <= i_fpd[EWIDTH+SWIDTH];     /* Sign is the top bit */
    o_unp.ex   <= ex;
    o_unp.sg   <= {~ex_zero, frac};         /* Hidden one only for normal numbers */
    o_unp.zero <= ex_zero;                  /* Subnormal fractions are ignored */
    o_unp.inf  <= ex_ones & ~frac_nz;
    o_unp.nan  <= ex_ones & frac_nz;
  end

endmodule

`default_nettype wire

// File: common/flp_unp_if.sv
/* Unpacked operand or result bundle passed between multiplier stages, driver on src and reader on dst */
`timescale 1ns/1ns
`default_nettype none

interface flp_unp_if #(
  parameter int EWIDTH = 8,   /* Exponent width */
  parameter int SWIDTH = 23   /* Fraction width without the hidden one */
);

  logic              sn;     /* Sign */
  logic [EWIDTH-1:0] ex;     /* Biased exponent */
  logic [SWIDTH:0]   sg;     /* Significand with the hidden one on top */
  logic              zero;   /* Value is zero or was flushed to zero */
  logic              nan;    /* Value is NaN */
  logic              inf;    /* Value is infinity */
  logic              valid;  /* One-cycle strobe qualifying the fields above */

  modport src (output sn, ex, sg, zero, nan, inf, valid);  /* Stage that drives the bundle */
  modport dst (input  sn, ex, sg, zero, nan, inf, valid);  /* Stage that consumes it */

endinterface

`default_nettype wire

// File: common/flp_pkg.sv
/* Shared rounding mode type, exception flag positions and latency for the multiplier and its bench */
`default_nettype none

package flp_pkg;

  /* Rounding modes held in the CSR and applied by the rounder */
  typedef enum logic
  {
    RM_RNE = 1'b0,  /* Round to nearest, ties to even */
    RM_RTZ = 1'b1   /* Round toward zero, plain truncation */
  } flp_rmode_e;

  /* Width of the exception word, both pulse and sticky */
  localparam int FLG_W = 4;

  /* Bit positions inside the exception word */
  localparam int FLG_INVALID   = 0;  /* Infinity times zero */
  localparam int FLG_OVERFLOW  = 1;  /* Result exponent too large */
  localparam int FLG_UNDERFLOW = 2;  /* Result flushed to zero */
  localparam int FLG_INEXACT   = 3;  /* Nonzero bits were dropped */

  /*
   * Cycles from i_valid to o_valid: one for unpack, two for the core
   * and one for the rounder, with pack combinational at the end
   */
  localparam int FLP_LATENCY = 4;

endpackage

`default_nettype wire
